// File: logic/video_pkg.sv
/*
 * Video input definitions
 * One cycle of the pixel stream and the default pixel and memory word widths
 */
package video_pkg;

    // Default widths, used by the top level as parameter defaults
    localparam int PIX_W_DEF  = 16;   // Bits per pixel
    localparam int AXI_DW_DEF = 64;   // Bits per memory word

    // One cycle of video input
    // frame_rst is a level, its falling edge marks a new frame
    typedef struct packed {
        logic                 frame_rst;
        logic                 frame_valid;   // Frame active
        logic                 line_valid;    // Line active
        logic [PIX_W_DEF-1:0] pix;
    } pix_beat_t;

endpackage

// File: logic/axi_wr_pkg.sv
/*
 * AXI4 write channel definitions
 * Channel structs, the line burst request and the FSM state encodings
 */
package axi_wr_pkg;
    import video_pkg::*;

    localparam int AXI_AW = 32;   // Address width

    // Line burst request, controller to burst writer
    typedef struct packed {
        logic [AXI_AW-1:0] addr;
        logic [7:0]        len;      // Beats minus one
    } wr_req_t;

    // AW channel, master side
    typedef struct packed {
        logic [AXI_AW-1:0] awaddr;
        logic [7:0]        awlen;
        logic [2:0]        awsize;
        logic [1:0]        awburst;
        logic              awvalid;
    } aw_chan_t;

    // W channel, master side
    typedef struct packed {
        logic [AXI_DW_DEF-1:0]   wdata;
        logic [AXI_DW_DEF/8-1:0] wstrb;
        logic                    wlast;
        logic                    wvalid;
    } w_chan_t;

    typedef enum logic [1:0] {ST_IDLE, ST_WAIT_LINE, ST_REQ, ST_BUSY} line_state_e;
    typedef enum logic [1:0] {BW_IDLE, BW_ADDR, BW_DATA, BW_RESP} burst_state_e;

endpackage

// File: logic/pixel_packer.sv
/*
 * Pixel packer
 * Collects AXI_DW/PIX_W consecutive pixels of a line into one memory word,
 * first pixel in the low bits, and pushes the word one cycle later
 */
`timescale 1ns/1ps

module pixel_packer
    import video_pkg::*;
#(
    parameter int PIX_W  = PIX_W_DEF,
    parameter int AXI_DW = AXI_DW_DEF
) (
    input  logic              i_clk_axi,
    input  logic              i_rst_axi,
    input  pix_beat_t         i_vid,
    output logic              o_push,
    output logic [AXI_DW-1:0] o_word
);
    localparam int PACK  = AXI_DW / PIX_W;
    localparam int SEL_W = (PACK > 1) ? $clog2(PACK) : 1;

    logic [PIX_W-1:0] pix;
    logic             pix_ok;
    logic             grp_end;
    logic [SEL_W-1:0] grp_cnt;   // Position inside the current group

    assign pix     = i_vid.pix;
    assign pix_ok  = i_vid.frame_valid && i_vid.line_valid && !i_vid.frame_rst;
    assign grp_end = pix_ok && (grp_cnt == SEL_W'(PACK - 1));

    always_ff @(posedge i_clk_axi) begin
        if (i_rst_axi) begin
            grp_cnt <= '0;
            o_push  <= 1'b0;
        end else begin
            o_push <= grp_end;   // Word is complete on the next cycle
            if (!pix_ok || grp_end) begin
                grp_cnt <= '0;
            end else begin
                grp_cnt <= grp_cnt + 1'b1;
            end
        end
    end

    // Shift in from the top so the oldest pixel ends up in the low bits
    always_ff @(posedge i_clk_axi) begin
        if (!pix_ok) begin
            o_word <= '0;
        end else begin
            o_word <= {pix, o_word[AXI_DW-1:PIX_W]};
        end
    end

endmodule

// File: logic/line_fifo.sv
/*
 * Line FIFO
 * Synchronous show-ahead buffer of memory words with an occupancy count
 */
`timescale 1ns/1ps

module line_fifo #(
    parameter int AXI_DW     = 64,
    parameter int FIFO_WORDS = 64,
    parameter int CNT_W      = $clog2(FIFO_WORDS + 1)
) (
    input  logic              i_clk_axi,
    input  logic              i_rst_axi,
    input  logic              i_flush,
    input  logic              i_push,
    input  logic [AXI_DW-1:0] i_word,
    input  logic              i_pop,
    output logic [AXI_DW-1:0] o_head,
    output logic [CNT_W-1:0]  o_count
);
    localparam int PTR_W = (FIFO_WORDS > 1) ? $clog2(FIFO_WORDS) : 1;

    logic [AXI_DW-1:0] mem [FIFO_WORDS];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic              full;
    logic              empty;
    logic              do_push;
    logic              do_pop;

    assign full    = (o_count == CNT_W'(FIFO_WORDS));
    assign empty   = (o_count == '0);
    assign do_push = i_push && !full;
    assign do_pop  = i_pop && !empty;
    assign o_head  = mem[rd_ptr];   // Show-ahead

    always_ff @(posedge i_clk_axi) begin
        if (do_push && !i_flush) begin
            mem[wr_ptr] <= i_word;
        end
    end

    always_ff @(posedge i_clk_axi) begin
        if (i_rst_axi || i_flush) begin
            wr_ptr  <= '0;
            rd_ptr  <= '0;
            o_count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_WORDS - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_WORDS - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   o_count <= o_count + 1'b1;
                2'b01:   o_count <= o_count - 1'b1;
                default: o_count <= o_count;
            endcase
        end
    end

    // Pixels have no back-pressure, an overflow loses a word
    a_no_overflow: assert property (@(posedge i_clk_axi) disable iff (i_rst_axi || i_flush)
        i_push |-> !full) else $error("line FIFO overflow");
    a_no_underflow: assert property (@(posedge i_clk_axi) disable iff (i_rst_axi || i_flush)
        i_pop |-> !empty) else $error("line FIFO underflow");

endmodule

// File: logic/line_write_ctrl.sv
/*
 * Line write controller
 * Waits for a full line in the FIFO, requests one burst per line and
 * steps the line address by the stride, reloading it on each new frame
 */
`timescale 1ns/1ps

module line_write_ctrl
    import axi_wr_pkg::*;
#(
    parameter int PIX_W      = 16,
    parameter int AXI_DW     = 64,
    parameter int XSIZE      = 64,
    parameter int XSTRIDE    = 80,
    parameter int FIFO_WORDS = 64,
    parameter int CNT_W      = $clog2(FIFO_WORDS + 1)
) (
    input  logic              i_clk_axi,
    input  logic              i_rst_axi,
    input  logic              i_frame_rst,
    input  logic [AXI_AW-1:0] i_base_addr,
    input  logic [CNT_W-1:0]  i_count,
    input  logic              i_done,
    output logic              o_start,
    output wr_req_t           o_req
);
    localparam int LINE_BEATS = XSIZE * PIX_W / AXI_DW;
    localparam int ADDR_INC   = XSTRIDE * PIX_W / 8;   // Bytes between line starts

    line_state_e       state;
    line_state_e       state_n;
    logic [AXI_AW-1:0] base_q;
    logic [AXI_AW-1:0] line_addr;
    logic              frame_rst_q;
    logic              frame_fall;
    logic              fall_pend;   // New frame seen during a burst
    logic              line_ready;

    // ************************************************************************
    // Frame reset edge and base address
    // ************************************************************************
    always_ff @(posedge i_clk_axi) begin
        base_q <= i_base_addr;
    end

    always_ff @(posedge i_clk_axi) begin
        if (i_rst_axi) begin
            frame_rst_q <= 1'b0;
        end else begin
            frame_rst_q <= i_frame_rst;
        end
    end

    assign frame_fall = frame_rst_q && !i_frame_rst;
    assign line_ready = (i_count >= CNT_W'(LINE_BEATS));

    // ************************************************************************
    // Line FSM
    // ************************************************************************
    always_comb begin
        state_n = state;
        case (state)
            ST_IDLE: begin
                if (frame_fall) state_n = ST_WAIT_LINE;   // First frame start
            end
            ST_WAIT_LINE: begin
                if (!frame_fall && line_ready) state_n = ST_REQ;
            end
            ST_REQ: begin
                state_n = frame_fall ? ST_WAIT_LINE : ST_BUSY;
            end
            ST_BUSY: begin
                if (i_done) state_n = ST_WAIT_LINE;
            end
            default: state_n = ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk_axi) begin
        if (i_rst_axi) begin
            state     <= ST_IDLE;
            fall_pend <= 1'b0;
        end else begin
            state <= state_n;
            if (state == ST_BUSY && i_done) begin
                fall_pend <= 1'b0;
            end else if (state == ST_BUSY && frame_fall) begin
                fall_pend <= 1'b1;
            end
        end
    end

    // Reload on a new frame, step after each finished line
    always_ff @(posedge i_clk_axi) begin
        if (state == ST_BUSY) begin
            if (i_done) begin
                line_addr <= (fall_pend || frame_fall) ? base_q : line_addr + AXI_AW'(ADDR_INC);
            end
        end else if (frame_fall) begin
            line_addr <= base_q;
        end
    end

    assign o_start   = (state == ST_REQ) && !frame_fall;   // Dropped if a frame restarts
    assign o_req.addr = line_addr;
    assign o_req.len  = 8'(LINE_BEATS - 1);

    a_line_fits: assert property (@(posedge i_clk_axi)
        LINE_BEATS inside {[1:256]}) else $error("line needs %0d beats", LINE_BEATS);
    a_done_when_busy: assert property (@(posedge i_clk_axi) disable iff (i_rst_axi)
        i_done |-> state == ST_BUSY) else $error("burst done without an open request");

endmodule

// File: logic/axi_burst_writer.sv
/*
 * AXI4 burst writer
 * Issues one incrementing write burst per request, streaming the beats
 * straight from the FIFO head, and pulses done after the write response
 */
`timescale 1ns/1ps

module axi_burst_writer
    import axi_wr_pkg::*;
#(
    parameter int AXI_DW     = 64,
    parameter int FIFO_WORDS = 64,
    parameter int CNT_W      = $clog2(FIFO_WORDS + 1)
) (
    input  logic              i_clk_axi,
    input  logic              i_rst_axi,
    input  logic              i_start,
    input  wr_req_t           i_req,
    input  logic [AXI_DW-1:0] i_head,
    input  logic [CNT_W-1:0]  i_count,
    output logic              o_pop,
    output aw_chan_t          o_aw,
    input  logic              i_awready,
    output w_chan_t           o_w,
    input  logic              i_wready,
    output logic              o_bready,
    input  logic              i_bvalid,
    output logic              o_done
);
    localparam logic [2:0] AW_SIZE    = 3'($clog2(AXI_DW / 8));
    localparam logic [1:0] BURST_INCR = 2'b01;

    burst_state_e      state;
    logic [AXI_AW-1:0] addr_q;
    logic [7:0]        len_q;
    logic [7:0]        beat_cnt;
    logic              awvalid_q;
    logic              wvalid;
    logic              wlast;

    assign wvalid   = (state == BW_DATA) && (i_count != '0);
    assign wlast    = (beat_cnt == len_q);
    assign o_pop    = wvalid && i_wready;   // One pop per W transfer
    assign o_bready = (state == BW_RESP);

    always_ff @(posedge i_clk_axi) begin
        if (i_rst_axi) begin
            state     <= BW_IDLE;
            awvalid_q <= 1'b0;
            beat_cnt  <= '0;
            o_done    <= 1'b0;
        end else begin
            o_done <= 1'b0;
            case (state)
                BW_IDLE: begin
                    if (i_start) begin
                        awvalid_q <= 1'b1;
                        state     <= BW_ADDR;
                    end
                end
                BW_ADDR: begin
                    if (i_awready) begin
                        awvalid_q <= 1'b0;
                        beat_cnt  <= '0;
                        state     <= BW_DATA;
                    end
                end
                BW_DATA: begin
                    if (o_pop) begin
                        beat_cnt <= beat_cnt + 1'b1;
                        if (wlast) state <= BW_RESP;
                    end
                end
                BW_RESP: begin
                    if (i_bvalid) begin
                        o_done <= 1'b1;
                        state  <= BW_IDLE;
                    end
                end
                default: state <= BW_IDLE;
            endcase
        end
    end

    // Request captured once per burst
    always_ff @(posedge i_clk_axi) begin
        if (state == BW_IDLE && i_start) begin
            addr_q <= i_req.addr;
            len_q  <= i_req.len;
        end
    end

    always_comb begin
        o_aw.awaddr  = addr_q;
        o_aw.awlen   = len_q;
        o_aw.awsize  = AW_SIZE;
        o_aw.awburst = BURST_INCR;
        o_aw.awvalid = awvalid_q;
        o_w.wdata    = i_head;
        o_w.wstrb    = '1;   // Full words only
        o_w.wlast    = wlast;
        o_w.wvalid   = wvalid;
    end

    a_aw_stable: assert property (@(posedge i_clk_axi) disable iff (i_rst_axi)
        o_aw.awvalid && !i_awready |=> $stable(o_aw)) else $error("AW changed while stalled");

endmodule

// File: logic/video_wr_dma.sv
/*
 * Video frame-buffer writer
 * Packs the pixel stream into memory words and writes each line to memory
 * as one AXI4 burst at a line address that advances by the stride
 */
`timescale 1ns/1ps

module video_wr_dma
    import video_pkg::*;
    import axi_wr_pkg::*;
#(
    parameter int PIX_W      = PIX_W_DEF,
    parameter int AXI_DW     = AXI_DW_DEF,
    parameter int XSIZE      = 64,     // Pixels per line
    parameter int XSTRIDE    = 80,     // Pixels between line starts
    parameter int FIFO_WORDS = 64
) (
    input  logic              i_clk_axi,
    input  logic              i_rst_axi,
    input  pix_beat_t         i_vid,
    input  logic [AXI_AW-1:0] i_base_addr,
    output aw_chan_t          o_aw,
    input  logic              i_awready,
    output w_chan_t           o_w,
    input  logic              i_wready,
    output logic              o_bready,
    input  logic              i_bvalid
);
    localparam int CNT_W = $clog2(FIFO_WORDS + 1);

    logic              push;
    logic [AXI_DW-1:0] word;
    logic              pop;
    logic [AXI_DW-1:0] head;
    logic [CNT_W-1:0]  count;
    logic              start;
    logic              done;
    wr_req_t           req;

    pixel_packer #(.PIX_W(PIX_W), .AXI_DW(AXI_DW)) u_pixel_packer (
        .i_clk_axi (i_clk_axi),
        .i_rst_axi (i_rst_axi),
        .i_vid     (i_vid),
        .o_push    (push),
        .o_word    (word)
    );

    line_fifo #(.AXI_DW(AXI_DW), .FIFO_WORDS(FIFO_WORDS), .CNT_W(CNT_W)) u_line_fifo (
        .i_clk_axi (i_clk_axi),
        .i_rst_axi (i_rst_axi),
        .i_flush   (i_vid.frame_rst),   // Drop partial data of the old frame
        .i_push    (push),
        .i_word    (word),
        .i_pop     (pop),
        .o_head    (head),
        .o_count   (count)
    );

    line_write_ctrl #(
        .PIX_W      (PIX_W),
        .AXI_DW     (AXI_DW),
        .XSIZE      (XSIZE),
        .XSTRIDE    (XSTRIDE),
        .FIFO_WORDS (FIFO_WORDS),
        .CNT_W      (CNT_W)
    ) u_line_write_ctrl (
        .i_clk_axi   (i_clk_axi),
        .i_rst_axi   (i_rst_axi),
        .i_frame_rst (i_vid.frame_rst),
        .i_base_addr (i_base_addr),
        .i_count     (count),
        .i_done      (done),
        .o_start     (start),
        .o_req       (req)
    );

    axi_burst_writer #(.AXI_DW(AXI_DW), .FIFO_WORDS(FIFO_WORDS), .CNT_W(CNT_W)) u_burst_writer (
        .i_clk_axi (i_clk_axi),
        .i_rst_axi (i_rst_axi),
        .i_start   (start),
        .i_req     (req),
        .i_head    (head),
        .i_count   (count),
        .o_pop     (pop),
        .o_aw      (o_aw),
        .i_awready (i_awready),
        .o_w       (o_w),
        .i_wready  (i_wready),
        .o_bready  (o_bready),
        .i_bvalid  (i_bvalid),
        .o_done    (done)
    );

endmodule

// File: sim/tb_video_wr_dma.sv
/*
 * Testbench for the video frame-buffer writer
 * Sends random lines over two frames into an AXI slave model with stalls
 * and compares every AW and W transfer with expected values
 */
`timescale 1ns/1ps

module tb_video_wr_dma
    import video_pkg::*;
    import axi_wr_pkg::*;
;
    localparam int PIX_W      = 16;
    localparam int AXI_DW     = 64;
    localparam int XSIZE      = 64;
    localparam int XSTRIDE    = 80;
    localparam int FIFO_WORDS = 64;
    localparam int PACK       = AXI_DW / PIX_W;
    localparam int LINE_BEATS = XSIZE * PIX_W / AXI_DW;
    localparam int ADDR_INC   = XSTRIDE * PIX_W / 8;
    localparam int NUM_LINES  = 8;      // Over both frames
    localparam int MAX_STALL  = 3;

    logic              clk_axi = 1'b0;
    logic              rst_axi;
    pix_beat_t         vid;
    logic [AXI_AW-1:0] base_addr;
    aw_chan_t          aw;
    w_chan_t           w;
    logic              awready;
    logic              wready;
    logic              bready;
    logic              bvalid;

    logic [31:0]       pix_rng   = 32'hba034507;
    logic [31:0]       stall_rng = ~32'hba034507;   // Separate stream for the slave
    logic [PIX_W-1:0]  sent_pix[$];                 // Pixels of whole lines, in order
    logic [AXI_AW-1:0] exp_addr[$];
    logic [AXI_AW-1:0] cur_base;
    int                line_idx, lines_sent, aw_count, w_beats, b_count, beat_in_burst;
    int                value_errs, proto_errs, aw_run, w_run;
    logic              burst_open, last_done, resp_due, b_taken, frame_begun;

    always #4 clk_axi = ~clk_axi;

    video_wr_dma #(
        .PIX_W(PIX_W), .AXI_DW(AXI_DW), .XSIZE(XSIZE), .XSTRIDE(XSTRIDE),
        .FIFO_WORDS(FIFO_WORDS)
    ) u_video_wr_dma (
        .i_clk_axi (clk_axi),
        .i_rst_axi (rst_axi),
        .i_vid     (vid),
        .i_base_addr (base_addr),
        .o_aw      (aw),
        .i_awready (awready),
        .o_w       (w),
        .i_wready  (wready),
        .o_bready  (bready),
        .i_bvalid  (bvalid)
    );

    // ************************************************************************
    // Reference model and helpers
    // ************************************************************************
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // First pixel of the group lands in the low bits
    function automatic logic [AXI_DW-1:0] expected_word(input int first);
        logic [AXI_DW-1:0] word;
        word = '0;
        for (int k = 0; k < PACK; k++) begin
            word[k*PIX_W +: PIX_W] = sent_pix[first + k];
        end
        return word;
    endfunction

    task automatic report_mismatch(input string sig, input logic [63:0] exp, got);
        value_errs++;
        $display("CHECK FAILED at %0t ns: %s expected %h got %h", $time, sig, exp, got);
    endtask

    task automatic report_protocol(input string what);
        proto_errs++;
        $display("Protocol error at %0t ns: %s", $time, what);
    endtask

    task automatic pick_ready(inout int run, output logic rdy);
        stall_rng = xorshift32(stall_rng);
        if (run < MAX_STALL && stall_rng[2:0] < 3'd2) begin   // About one cycle in four
            rdy = 1'b0;
            run = run + 1;
        end else begin
            rdy = 1'b1;
            run = 0;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_axi);
        #1;
    endtask

    // Frame reset pulse with a new base, junk pixels while it is high
    task automatic start_frame(input logic [AXI_AW-1:0] base, input int junk);
        next_cycle();
        frame_begun     = 1'b1;
        vid.frame_rst   = 1'b1;
        vid.frame_valid = 1'b0;
        vid.line_valid  = 1'b0;
        base_addr       = base;
        repeat (3) next_cycle();
        repeat (junk) begin
            next_cycle();
            pix_rng         = xorshift32(pix_rng);
            vid.frame_valid = 1'b1;
            vid.line_valid  = 1'b1;
            vid.pix         = pix_rng[PIX_W-1:0];
        end
        next_cycle();
        vid = '0;
        cur_base = base;
        line_idx = 0;
        repeat (4) next_cycle();
    endtask

    task automatic send_line();
        int gap;
        exp_addr.push_back(cur_base + AXI_AW'(line_idx * ADDR_INC));
        line_idx++;
        lines_sent++;
        for (int k = 0; k < XSIZE; k++) begin
            next_cycle();
            pix_rng         = xorshift32(pix_rng);
            vid.frame_valid = 1'b1;
            vid.line_valid  = 1'b1;
            vid.pix         = pix_rng[PIX_W-1:0];
            sent_pix.push_back(pix_rng[PIX_W-1:0]);
        end
        next_cycle();
        vid.line_valid = 1'b0;   // Frame stays active between lines
        pix_rng = xorshift32(pix_rng);
        gap = 8 + pix_rng[4:0];
        repeat (gap) next_cycle();
    endtask

    // ************************************************************************
    // AXI slave model, driven just after the clock edge
    // ************************************************************************
    always @(posedge clk_axi) begin
        #1;
        pick_ready(aw_run, awready);
        pick_ready(w_run, wready);
        if (b_taken) begin
            bvalid  = 1'b0;
            b_taken = 1'b0;
        end else if (resp_due) begin
            bvalid   = 1'b1;   // One cycle after the last beat
            resp_due = 1'b0;
        end
    end

    // Comparison at the falling edge, where all signals are settled
    always @(negedge clk_axi) begin
        if (!rst_axi) begin
            if (!frame_begun) begin
                assert (!aw.awvalid && !w.wvalid && !bready)
                    else report_protocol("valid or bready high before any pixels");
            end
            if (aw.awvalid) begin
                assert (!burst_open) else report_protocol("AW before write response");
            end
            if (aw.awvalid && awready) begin
                assert (exp_addr.size() != 0)
                    else report_protocol("AW transfer with no complete line sent");
                if (exp_addr.size() != 0) begin
                    assert (aw.awaddr == exp_addr[0])
                        else report_mismatch("awaddr", exp_addr[0], aw.awaddr);
                    void'(exp_addr.pop_front());
                end
                assert (aw.awlen == 8'(LINE_BEATS - 1))
                    else report_mismatch("awlen", LINE_BEATS - 1, aw.awlen);
                assert (aw.awsize == 3'd3) else report_mismatch("awsize", 3, aw.awsize);
                assert (aw.awburst == 2'b01) else report_mismatch("awburst", 1, aw.awburst);
                aw_count++;
                burst_open    = 1'b1;
                last_done     = 1'b0;
                beat_in_burst = 0;
            end
            if (w.wvalid && wready) begin
                assert (burst_open && !last_done) else report_protocol("W beat outside a burst");
                assert ((w_beats + 1) * PACK <= sent_pix.size())
                    else report_protocol("W beat with no matching pixels");
                if ((w_beats + 1) * PACK <= sent_pix.size()) begin
                    assert (w.wdata == expected_word(w_beats * PACK))
                        else report_mismatch("wdata", expected_word(w_beats * PACK), w.wdata);
                end
                assert (w.wstrb == '1) else report_mismatch("wstrb", 8'hff, w.wstrb);
                assert (w.wlast == (beat_in_burst == LINE_BEATS - 1))
                    else report_mismatch("wlast", beat_in_burst == LINE_BEATS - 1, w.wlast);
                w_beats++;
                beat_in_burst++;
                if (w.wlast) begin
                    last_done = 1'b1;
                    resp_due  = 1'b1;
                end
            end
            if (bready) begin
                assert (last_done) else report_protocol("bready before the last beat");
            end
            if (bvalid && bready) begin
                b_count++;
                burst_open = 1'b0;
                last_done  = 1'b0;
                b_taken    = 1'b1;
            end
        end
    end

    // ************************************************************************
    // Main sequence
    // ************************************************************************
    initial begin
        {burst_open, last_done, resp_due, b_taken, frame_begun} = '0;
        {line_idx, lines_sent, aw_count, w_beats, b_count, beat_in_burst} = '0;
        {value_errs, proto_errs, aw_run, w_run} = '0;
        rst_axi   = 1'b1;
        vid       = '0;
        base_addr = '0;
        awready   = 1'b0;
        wready    = 1'b0;
        bvalid    = 1'b0;
        repeat (10) @(posedge clk_axi);
        #1 rst_axi = 1'b0;
        repeat (8) next_cycle();
        start_frame(32'h1000_0000, 6);
        repeat (NUM_LINES / 2) send_line();
        while (b_count < lines_sent) @(posedge clk_axi);
        start_frame(32'h2000_4000, 20);   // New frame, pixels under reset dropped
        repeat (NUM_LINES / 2) send_line();
        while (b_count < lines_sent) @(posedge clk_axi);
        repeat (10) next_cycle();
        assert (aw_count == NUM_LINES) else report_mismatch("AW count", NUM_LINES, aw_count);
        assert (w_beats == NUM_LINES * LINE_BEATS)
            else report_mismatch("W beat count", NUM_LINES * LINE_BEATS, w_beats);
        $display("Errors: %0d value, %0d protocol", value_errs, proto_errs);
        if (value_errs == 0 && proto_errs == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (NUM_LINES * 300 + 2000) @(posedge clk_axi);
        $display("Timeout: bursts did not finish, %0d of %0d responses seen", b_count, NUM_LINES);
        $display("Testbench failed");
        $finish;
    end

endmodule

// File: vlog.f
logic/video_pkg.sv
logic/axi_wr_pkg.sv
logic/pixel_packer.sv
logic/line_fifo.sv
logic/line_write_ctrl.sv
logic/axi_burst_writer.sv
logic/video_wr_dma.sv
sim/tb_video_wr_dma.sv
